// ==== verilog/core_pkg.sv ====
package core_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    // Major opcodes handled by the core
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    // funct3 codes shared by OP and OP-IMM
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        // LUI result comes straight from the immediate
        alu_pass_b = 4'd10
    } alu_op_t;

endpackage

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import core_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            acki_n,
    input  logic [xlen-1:0] idt,
    output logic [xlen-1:0] iad,
    output logic            if_valid,
    output logic [xlen-1:0] if_ir
);

    logic [xlen-1:0] pc;

    assign iad = pc;

    // PC moves only on an acknowledged fetch, otherwise a bubble goes down
    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (!acki_n) begin
            pc       <= pc + xlen'(4);
            if_valid <= 1'b1;
        end else begin
            if_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!acki_n) begin
            if_ir <= idt;
        end
    end

    a_iad_aligned: assert property (
        @(posedge clk) disable iff (rst)
        iad[1:0] == 2'b00
    );

endmodule

// ==== verilog/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit import core_pkg::*; (
    input  logic                  if_valid,
    input  logic [xlen-1:0]       if_ir,
    output logic [reg_addr_w-1:0] rs1,
    output logic [reg_addr_w-1:0] rs2,
    output logic [reg_addr_w-1:0] rd,
    output alu_op_t               alu_op,
    output logic [xlen-1:0]       imm,
    output logic                  use_imm,
    output logic                  id_wr,
    output logic                  id_valid
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    logic       is_op;
    logic       is_op_imm;
    logic       is_lui;

    assign opcode = if_ir[6:0];
    assign rd     = if_ir[11:7];
    assign funct3 = if_ir[14:12];
    assign rs1    = if_ir[19:15];
    assign rs2    = if_ir[24:20];
    // funct7 bit 5 selects SUB and SRA/SRAI
    assign alt    = if_ir[30];

    assign is_op     = (opcode == opc_op);
    assign is_op_imm = (opcode == opc_op_imm);
    assign is_lui    = (opcode == opc_lui);

    assign imm = is_lui ? {if_ir[31:12], 12'b0} : {{20{if_ir[31]}}, if_ir[31:20]};
    assign use_imm = is_op_imm || is_lui;

    always_comb begin
        alu_op = alu_add;
        case (funct3)
            // ADDI has no SUB form
            f3_add:  alu_op = (is_op && alt) ? alu_sub : alu_add;
            f3_sll:  alu_op = alu_sll;
            f3_slt:  alu_op = alu_slt;
            f3_sltu: alu_op = alu_sltu;
            f3_xor:  alu_op = alu_xor;
            f3_sr:   alu_op = alt ? alu_sra : alu_srl;
            f3_or:   alu_op = alu_or;
            f3_and:  alu_op = alu_and;
        endcase
        if (is_lui) begin
            alu_op = alu_pass_b;
        end
    end

    // Unknown opcodes go down as bubbles
    assign id_valid = if_valid && (is_op || is_op_imm || is_lui);
    assign id_wr    = id_valid && (rd != '0);

endmodule

// ==== verilog/rf32x32.sv ====
`timescale 1ns/1ps

module rf32x32 import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  logic                  wr_en,
    input  logic [reg_addr_w-1:0] wr_addr,
    input  logic [xlen-1:0]       wr_data,
    output logic [xlen-1:0]       rd1_data,
    output logic [xlen-1:0]       rd2_data
);

    logic [xlen-1:0] regs [1 << reg_addr_w];

    // x0 is never written so it stays zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd1_data = regs[rs1];
    assign rd2_data = regs[rs2];

    a_no_x0_write: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> wr_addr != '0
    );

endmodule

// ==== verilog/forward_unit.sv ====
`timescale 1ns/1ps

module forward_unit import core_pkg::*; (
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  logic [xlen-1:0]       rd1_data,
    input  logic [xlen-1:0]       rd2_data,
    input  logic                  ex_wr,
    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic [xlen-1:0]       ex_result,
    input  logic                  wb_wr,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic [xlen-1:0]       wb_data,
    output logic [xlen-1:0]       op_a,
    output logic [xlen-1:0]       op_b
);

    // EX has priority over WB and WB over the register file
    function automatic logic [xlen-1:0] pick(
        input logic [reg_addr_w-1:0] src,
        input logic [xlen-1:0]       rf_val
    );
        if (ex_wr && ex_rd == src) begin
            return ex_result;
        end else if (wb_wr && wb_rd == src) begin
            return wb_data;
        end else begin
            return rf_val;
        end
    endfunction

    always_comb begin
        op_a = pick(rs1, rd1_data);
        op_b = pick(rs2, rd2_data);
    end

endmodule

// ==== verilog/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  id_valid,
    input  logic                  id_wr,
    input  logic [reg_addr_w-1:0] rd,
    input  alu_op_t               alu_op,
    input  logic [xlen-1:0]       imm,
    input  logic                  use_imm,
    input  logic [xlen-1:0]       op_a,
    input  logic [xlen-1:0]       op_b,
    output logic                  ex_wr,
    output logic [reg_addr_w-1:0] ex_rd,
    output logic [xlen-1:0]       ex_result,
    output logic                  wb_wr,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [xlen-1:0]       wb_data
);

    logic            ex_valid;
    logic            ex_wr_q;
    alu_op_t         ex_alu_op;
    logic            ex_use_imm;
    logic [xlen-1:0] ex_imm;
    logic [xlen-1:0] ex_a;
    logic [xlen-1:0] ex_b;
    logic [xlen-1:0] alu_b;

    // ID/EX register
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_wr_q  <= 1'b0;
        end else begin
            ex_valid <= id_valid;
            ex_wr_q  <= id_wr;
        end
    end

    always_ff @(posedge clk) begin
        ex_rd      <= rd;
        ex_alu_op  <= alu_op;
        ex_use_imm <= use_imm;
        ex_imm     <= imm;
        ex_a       <= op_a;
        ex_b       <= op_b;
    end

    assign ex_wr = ex_valid && ex_wr_q;
    assign alu_b = ex_use_imm ? ex_imm : ex_b;

    always_comb begin
        case (ex_alu_op)
            alu_add:    ex_result = ex_a + alu_b;
            alu_sub:    ex_result = ex_a - alu_b;
            alu_sll:    ex_result = ex_a << alu_b[4:0];
            alu_slt:    ex_result = xlen'($signed(ex_a) < $signed(alu_b));
            alu_sltu:   ex_result = xlen'(ex_a < alu_b);
            alu_xor:    ex_result = ex_a ^ alu_b;
            alu_srl:    ex_result = ex_a >> alu_b[4:0];
            alu_sra:    ex_result = $signed(ex_a) >>> alu_b[4:0];
            alu_or:     ex_result = ex_a | alu_b;
            alu_and:    ex_result = ex_a & alu_b;
            alu_pass_b: ex_result = alu_b;
            default:    ex_result = '0;
        endcase
    end

    // EX/WB register drives the retire port
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_wr <= 1'b0;
        end else begin
            wb_wr <= ex_wr;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= ex_rd;
        wb_data <= ex_result;
    end

    a_wb_quiet_after_rst: assert property (
        @(posedge clk) $fell(rst) |-> !wb_wr ##1 !wb_wr
    );

endmodule

// ==== verilog/core_top.sv ====
`timescale 1ns/1ps

module core_top import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [xlen-1:0]       idt,
    input  logic                  acki_n,
    output logic [xlen-1:0]       iad,
    output logic                  retire_valid,
    output logic [reg_addr_w-1:0] retire_rd,
    output logic [xlen-1:0]       retire_data
);

    // IF/ID
    logic                  if_valid;
    logic [xlen-1:0]       if_ir;

    // Decode
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    alu_op_t               alu_op;
    logic [xlen-1:0]       imm;
    logic                  use_imm;
    logic                  id_wr;
    logic                  id_valid;

    // Operands
    logic [xlen-1:0]       rd1_data;
    logic [xlen-1:0]       rd2_data;
    logic [xlen-1:0]       op_a;
    logic [xlen-1:0]       op_b;

    // Execute and write-back
    logic                  ex_wr;
    logic [reg_addr_w-1:0] ex_rd;
    logic [xlen-1:0]       ex_result;
    logic                  wb_wr;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;

    fetch_unit fetch_i (
        .clk(clk), .rst(rst), .acki_n(acki_n), .idt(idt),
        .iad(iad), .if_valid(if_valid), .if_ir(if_ir)
    );

    decode_unit decode_i (
        .if_valid(if_valid), .if_ir(if_ir),
        .rs1(rs1), .rs2(rs2), .rd(rd), .alu_op(alu_op), .imm(imm),
        .use_imm(use_imm), .id_wr(id_wr), .id_valid(id_valid)
    );

    rf32x32 rf_i (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2),
        .wr_en(wb_wr), .wr_addr(wb_rd), .wr_data(wb_data),
        .rd1_data(rd1_data), .rd2_data(rd2_data)
    );

    forward_unit forward_i (
        .rs1(rs1), .rs2(rs2), .rd1_data(rd1_data), .rd2_data(rd2_data),
        .ex_wr(ex_wr), .ex_rd(ex_rd), .ex_result(ex_result),
        .wb_wr(wb_wr), .wb_rd(wb_rd), .wb_data(wb_data),
        .op_a(op_a), .op_b(op_b)
    );

    ex_stage ex_i (
        .clk(clk), .rst(rst), .id_valid(id_valid), .id_wr(id_wr), .rd(rd),
        .alu_op(alu_op), .imm(imm), .use_imm(use_imm), .op_a(op_a), .op_b(op_b),
        .ex_wr(ex_wr), .ex_rd(ex_rd), .ex_result(ex_result),
        .wb_wr(wb_wr), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    assign retire_valid = wb_wr;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

// ==== sim/core_tb.sv ====
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

    logic            clk;
    logic            rst;
    logic            acki_n;
    logic [31:0]     idt;
    logic [31:0]     iad;
    logic            retire_valid;
    logic [4:0]      retire_rd;
    logic [31:0]     retire_data;

    logic [31:0] prog_word[$];
    logic [4:0]  prog_dest[$];
    logic [4:0]  exp_rd[$];
    logic [31:0] exp_data[$];
    logic [31:0] ref_regs[32];
    logic [31:0] rng_state;
    logic [31:0] exp_pc;
    int          sb_idx = 0;

    core_top dut_i (
        .clk(clk), .rst(rst), .idt(idt), .acki_n(acki_n),
        .iad(iad), .retire_valid(retire_valid), .retire_rd(retire_rd),
        .retire_data(retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic [6:0] f7,
                                          input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc_op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input int rd,
                                          input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), opc_op_imm};
    endfunction

    function automatic logic [31:0] enc_u(input int rd, input int imm20);
        return {20'(imm20), 5'(rd), opc_lui};
    endfunction

    task automatic add_row(input logic [31:0] word, input logic [4:0] dest);
        prog_word.push_back(word);
        prog_dest.push_back(dest);
    endtask

    // Destination 0 marks a row that must not retire
    task automatic load_program();
        add_row(enc_u(1, 'h80000), 1);
        add_row(enc_i(f3_add, 2, 0, -7), 2);
        add_row(enc_i(f3_add, 3, 0, 5), 3);
        add_row(enc_r(f3_add, 7'h00, 4, 2, 3), 4);
        add_row(enc_r(f3_add, 7'h20, 5, 4, 3), 5);
        add_row(enc_r(f3_slt, 7'h00, 6, 2, 3), 6);
        add_row(enc_r(f3_sltu, 7'h00, 7, 2, 3), 7);
        add_row(enc_r(f3_xor, 7'h00, 8, 2, 3), 8);
        add_row(enc_r(f3_sll, 7'h00, 9, 3, 3), 9);
        add_row(enc_r(f3_sr, 7'h00, 10, 1, 3), 10);
        add_row(enc_r(f3_sr, 7'h20, 11, 1, 3), 11);
        add_row(enc_r(f3_or, 7'h00, 12, 1, 3), 12);
        add_row(enc_r(f3_and, 7'h00, 13, 2, 4), 13);
        add_row(enc_i(f3_slt, 14, 2, -1), 14);
        add_row(enc_i(f3_sltu, 15, 3, -1), 15);
        add_row(enc_i(f3_xor, 16, 2, -1), 16);
        add_row(enc_i(f3_or, 17, 3, 'h0f0), 17);
        add_row(enc_i(f3_and, 18, 2, 'h0ff), 18);
        add_row(enc_i(f3_sll, 19, 3, 31), 19);
        add_row(enc_i(f3_sr, 20, 2, 4), 20);
        add_row(enc_i(f3_sr, 21, 2, 'h404), 21);
        // x0 as destination, then x0 as source right behind it
        add_row(enc_r(f3_add, 7'h00, 0, 1, 2), 0);
        add_row(enc_r(f3_add, 7'h00, 22, 0, 3), 22);
        add_row(enc_i(f3_add, 0, 3, 9), 0);
        add_row(enc_r(f3_or, 7'h00, 23, 0, 0), 23);
        add_row(enc_u(24, 'h12345), 24);
        add_row(enc_i(f3_add, 24, 24, 'h678), 24);
        add_row(enc_i(f3_add, 25, 24, -1), 25);
        add_row(enc_r(f3_add, 7'h00, 26, 24, 25), 26);
        add_row(enc_i(f3_add, 0, 0, 0), 0);
        add_row(enc_r(f3_add, 7'h20, 27, 26, 24), 27);
        add_row(enc_r(f3_sr, 7'h20, 28, 2, 3), 28);
        add_row(enc_r(f3_slt, 7'h00, 29, 3, 2), 29);
        add_row(enc_r(f3_sltu, 7'h00, 30, 3, 2), 30);
    endtask

    // Reference ALU straight from the ISA encoding
    function automatic logic [31:0] ref_exec(input logic [31:0] word);
        logic [31:0] a;
        logic [31:0] b;
        a = ref_regs[word[19:15]];
        if (word[6:0] == opc_lui) begin
            return {word[31:12], 12'h000};
        end
        b = (word[6:0] == opc_op) ? ref_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
        case (word[14:12])
            3'd0: return (word[6:0] == opc_op && word[30]) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (word[30]) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_expected();
        logic [31:0] value;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        foreach (prog_word[i]) begin
            value = ref_exec(prog_word[i]);
            if (prog_dest[i] != 5'd0) begin
                ref_regs[prog_dest[i]] = value;
                exp_rd.push_back(prog_dest[i]);
                exp_data.push_back(value);
            end
        end
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if ((addr >> 2) < prog_word.size()) begin
            return prog_word[addr >> 2];
        end
        return enc_i(f3_add, 0, 0, 0);
    endfunction

    task automatic drive_cycle();
        rng_state = xorshift32(rng_state);
        acki_n = (rng_state[9:8] == 2'b00);
        idt = fetch_word(iad);
        @(posedge clk);
        #1;
        if (!acki_n) begin
            exp_pc = exp_pc + 32'd4;
        end
        check("iad", iad, exp_pc);
    endtask

    // Retires must follow program order exactly
    always @(negedge clk) begin
        if (!rst && retire_valid) begin
            if (sb_idx >= exp_rd.size()) begin
                $display("Extra retire to x%0d after the whole program had retired", retire_rd);
                abort_run();
            end else begin
                check($sformatf("retire_rd[%0d]", sb_idx), 32'(retire_rd), 32'(exp_rd[sb_idx]));
                check($sformatf("retire_data[%0d]", sb_idx), retire_data, exp_data[sb_idx]);
                sb_idx++;
            end
        end
    end

    initial begin
        int limit;
        @(negedge rst);
        limit = prog_word.size() * 8 + 50;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired, the program did not finish within %0d cycles", limit);
        abort_run();
    end

    initial begin
        rst = 1'b1;
        acki_n = 1'b1;
        idt = '0;
        rng_state = 32'd32;
        exp_pc = '0;
        load_program();
        build_expected();
        repeat (5) begin
            @(posedge clk);
            #1;
            check("retire_valid", 32'(retire_valid), 32'd0);
            check("iad", iad, 32'd0);
        end
        rst = 1'b0;
        while (sb_idx < exp_rd.size()) begin
            drive_cycle();
        end
        // Drain a few cycles so a repeated retire would still show up
        repeat (12) drive_cycle();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== core_top.f ====
verilog/core_pkg.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/rf32x32.sv
verilog/forward_unit.sv
verilog/ex_stage.sv
verilog/core_top.sv
sim/core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= core_tb
FILELIST  ?= core_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "all tests passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
